// ==== verification/alu_golden.hex ====
// columns: cmd_branch_rs1_rs2_expected-result_expected-flag, all hex
// a line with command ff ends the vectors
01_0_00000005_00000007_0000000c_0 // add
0a_0_00000005_00000007_fffffffe_0 // sub
02_3_ffffffff_00000001_00000001_1 // slt, br_lt
03_3_ffffffff_00000001_00000000_0 // sltu, br_lt
04_0_f0f0f0f0_ff00ff00_0ff00ff0_0
05_0_f0f0f0f0_0f000000_fff0f0f0_0
06_0_f0f0f0f0_ff00ff00_f000f000_0
07_0_00000001_0000001f_80000000_0 // sll by 31
08_0_80000000_00000020_80000000_0 // srl by 0, upper shamt bits ignored
09_0_80000000_0000001f_ffffffff_0 // sra by 31
03_1_00000005_00000005_00000000_1 // sltu, br_eq
02_2_00000005_00000005_00000000_0 // slt, br_ne
03_4_ffffffff_00000001_00000000_1 // sltu, br_ge
02_4_ffffffff_00000001_00000001_0 // slt, br_ge
03_2_00000001_00000002_00000001_1 // sltu, br_ne
4e_0_80000001_0000001f_c0000000_0 // rol by 31
4f_0_80000001_00000000_80000001_0 // ror by 0
53_0_00000000_0000001f_80000000_0 // bset bit 31
51_0_80000000_0000001f_00000001_0 // bext bit 31
55_0_00008000_00000000_ffff8000_0 // sext.h
58_0_00000003_00000001_00000019_0 // sh3add
47_0_ffffffff_00000001_00000001_0 // max, signed
4a_0_ffffffff_00000001_00000001_0 // minu
44_0_00000000_00000000_00000020_0 // clz of 0
46_0_80000000_00000000_0000001f_0 // ctz
45_0_ffffffff_00000000_00000020_0 // cpop
44_0_00000001_00000000_0000001f_0 // clz of 1
42_0_80000000_80000000_40000000_0 // clmulh
43_0_ffffffff_ffffffff_aaaaaaaa_0 // clmulr
41_0_ffffffff_ffffffff_55555555_0 // clmul
0b_0_12345678_87654321_00000000_0 // unknown base code
45_0_00000001_00000000_00000001_0 // cpop of 1
5b_0_12345678_87654321_00000000_0 // unknown bit-manip code
ff_0_00000000_00000000_00000000_0

// ==== compile.f ====
hdl/alu_op_pkg.sv
hdl/branch_pkg.sv
hdl/compare_unit.sv
hdl/base_int_unit.sv
hdl/bit_count_unit.sv
hdl/clmul_unit.sv
hdl/bitmanip_unit.sv
hdl/result_reg.sv
hdl/alu_top.sv
verification/alu_checker.sv
verification/alu_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module alu_tb -Mdir obj_dir -f compile.f

run: compile
	./obj_dir/Valu_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb import alu_op_pkg::*, branch_pkg::*; ();

    localparam int MAX_VEC = 256;   // 8-bit vector index

    logic           clk = 1'b0;
    logic           reset;
    alu_cmd_u       alu_cmd;
    logic [2:0]     zero_cmd;
    logic [31:0]    rs1_data;
    logic [31:0]    rs2_data;
    logic [31:0]    rd_data;
    logic           zero;

    logic           vec_valid;
    logic [7:0]     vec_idx;
    logic [111:0]   golden [MAX_VEC];
    int             nvec = 0;
    int             cycles = 0;
    int             error_count;
    int             check_count;

    alu_top #(.XLEN(32)) dut (
        .clk_i      (clk),
        .reset_i    (reset),
        .alu_cmd_i  (alu_cmd),
        .zero_cmd_i (zero_cmd),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rd_data_o  (rd_data),
        .zero_o     (zero)
    );

    alu_checker #(.MAX_VEC(MAX_VEC)) u_checker (
        .clk_i         (clk),
        .reset_i       (reset),
        .vec_valid_i   (vec_valid),
        .vec_idx_i     (vec_idx),
        .rd_data_i     (rd_data),
        .zero_i        (zero),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    ////////////////////
    // stimulus helpers
    task automatic drive_idle();
        alu_cmd.raw = 7'd0;   // unknown code, result 0
        zero_cmd    = br_none;
        rs1_data    = '0;
        rs2_data    = '0;
        vec_idx     = '0;
        vec_valid   = 1'b0;
    endtask

    // nonzero result and a set flag, only reset keeps the outputs low
    task automatic drive_busy();
        alu_cmd.raw = cmd_add;
        zero_cmd    = br_eq;
        rs1_data    = 32'h0000_1234;
        rs2_data    = 32'h0000_1234;
        vec_idx     = '0;
        vec_valid   = 1'b0;
    endtask

    task automatic drive_vector(input logic [7:0] idx);
        alu_cmd.raw = golden[idx][110:104];
        zero_cmd    = golden[idx][102:100];
        rs1_data    = golden[idx][99:68];
        rs2_data    = golden[idx][67:36];
        vec_idx     = idx;
        vec_valid   = 1'b1;
    endtask

    // vectors end at the first line with command field ff
    function automatic int find_end_marker();
        for (int i = 0; i < MAX_VEC; i++) begin
            if (golden[8'(i)][111:104] == 8'hff) begin
                return i;
            end
        end
        return 0;
    endfunction

    initial begin
        forever #5 clk = ~clk;
    end

    ////////////////////
    // main sequence
    initial begin
        reset = 1'b1;
        drive_busy();
        $readmemh("verification/alu_golden.hex", golden);
        nvec = find_end_marker();
        if (nvec == 0) begin
            $display("golden file is missing or has no end marker, nothing was run");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            #1;
            reset = 1'b0;
            drive_idle();
            @(posedge clk);   // first edge after reset, idle inputs
            for (int k = 0; k < nvec; k++) begin
                #1;
                drive_vector(8'(k));
                @(posedge clk);
            end
            #1;
            drive_idle();
            @(posedge clk);
            @(negedge clk);   // idle result checked here
            #1;
            $display("vectors: %0d, checked: %0d, errors: %0d", nvec, check_count, error_count);
            if (error_count == 0 && check_count == nvec) begin
                $display("TESTBENCH PASSED");
            end else begin
                if (check_count != nvec) begin
                    $display("checker compared %0d results for %0d vectors", check_count, nvec);
                end
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

    // run limit from reset length and vector count
    initial begin
        @(posedge clk);
        cycles = 1;
        while (cycles < 5 + nvec + 20) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== verification/alu_checker.sv ====
`timescale 1ns/1ps

module alu_checker import alu_op_pkg::*; #(
    parameter int MAX_VEC = 256
) (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          vec_valid_i,
    input  logic [7:0]    vec_idx_i,
    input  logic [31:0]   rd_data_i,
    input  logic          zero_i,
    output int            error_count_o,
    output int            check_count_o
);

    logic [111:0]  golden [MAX_VEC];
    logic [111:0]  cur_vec;
    logic          cap_valid;
    logic [7:0]    cap_idx;
    int            errors = 0;
    int            checks = 0;

    function automatic string cmd_name(input logic [6:0] code);
        case (code)
            cmd_add:    return "add";
            cmd_slt:    return "slt";
            cmd_sltu:   return "sltu";
            cmd_xor:    return "xor";
            cmd_or:     return "or";
            cmd_and:    return "and";
            cmd_sll:    return "sll";
            cmd_srl:    return "srl";
            cmd_sra:    return "sra";
            cmd_sub:    return "sub";
            cmd_andn:   return "andn";
            cmd_clmul:  return "clmul";
            cmd_clmulh: return "clmulh";
            cmd_clmulr: return "clmulr";
            cmd_clz:    return "clz";
            cmd_cpop:   return "cpop";
            cmd_ctz:    return "ctz";
            cmd_max:    return "max";
            cmd_maxu:   return "maxu";
            cmd_min:    return "min";
            cmd_minu:   return "minu";
            cmd_orcb:   return "orc.b";
            cmd_orn:    return "orn";
            cmd_rev8:   return "rev8";
            cmd_rol:    return "rol";
            cmd_ror:    return "ror";
            cmd_bclr:   return "bclr";
            cmd_bext:   return "bext";
            cmd_binv:   return "binv";
            cmd_bset:   return "bset";
            cmd_sextb:  return "sext.b";
            cmd_sexth:  return "sext.h";
            cmd_sh1add: return "sh1add";
            cmd_sh2add: return "sh2add";
            cmd_sh3add: return "sh3add";
            cmd_xnor:   return "xnor";
            cmd_zexth:  return "zext.h";
            default:    return "unknown";
        endcase
    endfunction

    initial begin
        $readmemh("verification/alu_golden.hex", golden);
    end

    assign cur_vec       = golden[cap_idx];
    assign error_count_o = errors;
    assign check_count_o = checks;

    // vector driven after edge k, its result visible after edge k+1
    always @(posedge clk_i) begin
        if (reset_i) begin
            cap_valid <= 1'b0;
            cap_idx   <= '0;
        end else begin
            cap_valid <= vec_valid_i;
            cap_idx   <= vec_idx_i;
        end
    end

    ////////////////////
    // compare mid-cycle, outputs settled
    always @(negedge clk_i) begin
        if (cap_valid) begin
            checks++;
            if (rd_data_i !== cur_vec[35:4] || zero_i !== cur_vec[0]) begin
                errors++;
                $display("ERROR at %0t ns: vector %0d %s expected %h/%b, got %h/%b",
                         $time, cap_idx, cmd_name(cur_vec[110:104]),
                         cur_vec[35:4], cur_vec[0], rd_data_i, zero_i);
            end
        end else if (rd_data_i !== '0 || zero_i !== 1'b0) begin
            errors++;   // reset or idle cycle
            $display("ERROR at %0t ns: outputs not zero in reset or idle, got %h/%b",
                     $time, rd_data_i, zero_i);
        end
    end

endmodule

// ==== hdl/alu_top.sv ====
`timescale 1ns/1ps

module alu_top import alu_op_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  alu_cmd_u          alu_cmd_i,
    input  logic [2:0]        zero_cmd_i,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    output logic [XLEN-1:0]   rd_data_o,
    output logic              zero_o
);

    logic              less;
    logic              branch_flag;
    logic [XLEN-1:0]   int_result;
    logic [XLEN-1:0]   b_result;

    compare_unit #(.XLEN(XLEN)) u_compare (
        .alu_cmd_i     (alu_cmd_i),
        .zero_cmd_i    (zero_cmd_i),
        .rs1_i         (rs1_data_i),
        .rs2_i         (rs2_data_i),
        .less_o        (less),
        .equal_o       (),
        .branch_flag_o (branch_flag)
    );

    base_int_unit #(.XLEN(XLEN)) u_base_int (
        .alu_cmd_i    (alu_cmd_i),
        .rs1_i        (rs1_data_i),
        .rs2_i        (rs2_data_i),
        .less_i       (less),
        .int_result_o (int_result)
    );

    bitmanip_unit #(.XLEN(XLEN)) u_bitmanip (
        .alu_cmd_i  (alu_cmd_i),
        .rs1_i      (rs1_data_i),
        .rs2_i      (rs2_data_i),
        .less_i     (less),
        .b_result_o (b_result)
    );

    result_reg #(.XLEN(XLEN)) u_result_reg (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alu_cmd_i     (alu_cmd_i),
        .zero_cmd_i    (zero_cmd_i),
        .int_result_i  (int_result),
        .b_result_i    (b_result),
        .branch_flag_i (branch_flag),
        .rd_data_o     (rd_data_o),
        .zero_o        (zero_o)
    );

endmodule

// ==== hdl/result_reg.sv ====
`timescale 1ns/1ps

module result_reg import alu_op_pkg::*, branch_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  alu_cmd_u          alu_cmd_i,
    input  logic [2:0]        zero_cmd_i,
    input  logic [XLEN-1:0]   int_result_i,
    input  logic [XLEN-1:0]   b_result_i,
    input  logic              branch_flag_i,
    output logic [XLEN-1:0]   rd_data_o,
    output logic              zero_o
);

    logic [XLEN-1:0] sel_result;

    assign sel_result = alu_cmd_i.fields.b_ext ? b_result_i : int_result_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_data_o <= '0;
            zero_o    <= 1'b0;
        end else begin
            rd_data_o <= sel_result;
            zero_o    <= branch_flag_i;   // one cycle behind the command
        end
    end

    // no branch code, no flag on the next edge
    a_no_branch_flag: assert property (@(posedge clk_i) disable iff (reset_i)
        zero_cmd_i == br_none |=> !zero_o)
        else $error("zero_o high after br_none");

endmodule

// ==== hdl/bitmanip_unit.sv ====
`timescale 1ns/1ps

module bitmanip_unit import alu_op_pkg::*; #(
    parameter int XLEN = 32
) (
    input  alu_cmd_u          alu_cmd_i,
    input  logic [XLEN-1:0]   rs1_i,
    input  logic [XLEN-1:0]   rs2_i,
    input  logic              less_i,
    output logic [XLEN-1:0]   b_result_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0]  shamt;
    logic [XLEN-1:0]     bit_mask;
    logic [2*XLEN-1:0]   rot_left;
    logic [2*XLEN-1:0]   rot_right;
    logic [XLEN-1:0]     count;
    logic [XLEN-1:0]     product;

    assign shamt     = rs2_i[SHAMT_W-1:0];          // modulo XLEN
    assign bit_mask  = XLEN'(1) << shamt;           // single-bit ops
    assign rot_left  = {rs1_i, rs1_i} << shamt;
    assign rot_right = {rs1_i, rs1_i} >> shamt;

    bit_count_unit #(.XLEN(XLEN)) u_bit_count (
        .alu_cmd_i (alu_cmd_i),
        .rs1_i     (rs1_i),
        .count_o   (count)
    );

    clmul_unit #(.XLEN(XLEN)) u_clmul (
        .alu_cmd_i (alu_cmd_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .product_o (product)
    );

    ////////////////////
    // group result select
    always_comb begin
        b_result_o = '0;
        case (alu_cmd_i.raw)
            cmd_andn:   b_result_o = rs1_i & ~rs2_i;
            cmd_orn:    b_result_o = rs1_i | ~rs2_i;
            cmd_xnor:   b_result_o = ~(rs1_i ^ rs2_i);
            cmd_orcb: begin
                for (int i = 0; i < XLEN; i += 8) begin
                    b_result_o[i +: 8] = {8{|rs1_i[i +: 8]}};   // byte all ones if any set
                end
            end
            cmd_rev8: begin
                for (int i = 0; i < XLEN; i += 8) begin
                    b_result_o[i +: 8] = rs1_i[XLEN-8-i +: 8];
                end
            end
            cmd_rol:    b_result_o = rot_left[2*XLEN-1:XLEN];
            cmd_ror:    b_result_o = rot_right[XLEN-1:0];
            cmd_bclr:   b_result_o = rs1_i & ~bit_mask;
            cmd_bext:   b_result_o = XLEN'(rs1_i[shamt]);
            cmd_binv:   b_result_o = rs1_i ^ bit_mask;
            cmd_bset:   b_result_o = rs1_i | bit_mask;
            cmd_sextb:  b_result_o = {{(XLEN-8){rs1_i[7]}}, rs1_i[7:0]};
            cmd_sexth:  b_result_o = {{(XLEN-16){rs1_i[15]}}, rs1_i[15:0]};
            cmd_zexth:  b_result_o = {{(XLEN-16){1'b0}}, rs1_i[15:0]};
            cmd_sh1add: b_result_o = (rs1_i << 1) + rs2_i;
            cmd_sh2add: b_result_o = (rs1_i << 2) + rs2_i;
            cmd_sh3add: b_result_o = (rs1_i << 3) + rs2_i;
            cmd_max,
            cmd_maxu:   b_result_o = less_i ? rs2_i : rs1_i;
            cmd_min,
            cmd_minu:   b_result_o = less_i ? rs1_i : rs2_i;
            cmd_clz,
            cmd_ctz,
            cmd_cpop:   b_result_o = count;
            cmd_clmul,
            cmd_clmulh,
            cmd_clmulr: b_result_o = product;
            default: begin
                b_result_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/clmul_unit.sv ====
`timescale 1ns/1ps

module clmul_unit import alu_op_pkg::*; #(
    parameter int XLEN = 32
) (
    input  alu_cmd_u          alu_cmd_i,
    input  logic [XLEN-1:0]   rs1_i,
    input  logic [XLEN-1:0]   rs2_i,
    output logic [XLEN-1:0]   product_o
);

    logic [2*XLEN-1:0] prod;

    ////////////////////
    // full carry-less product
    always_comb begin
        prod = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (rs2_i[i]) prod = prod ^ ({{XLEN{1'b0}}, rs1_i} << i);
        end
    end

    always_comb begin
        case (alu_cmd_i.raw)
            cmd_clmul:  product_o = prod[XLEN-1:0];
            cmd_clmulh: product_o = prod[2*XLEN-1:XLEN];
            cmd_clmulr: product_o = prod[2*XLEN-2:XLEN-1];   // bit-reversed form
            default:    product_o = '0;
        endcase
    end

endmodule

// ==== hdl/bit_count_unit.sv ====
`timescale 1ns/1ps

module bit_count_unit import alu_op_pkg::*; #(
    parameter int XLEN = 32
) (
    input  alu_cmd_u          alu_cmd_i,
    input  logic [XLEN-1:0]   rs1_i,
    output logic [XLEN-1:0]   count_o
);

    logic [XLEN-1:0] lead_cnt;
    logic [XLEN-1:0] trail_cnt;
    logic [XLEN-1:0] pop_cnt;

    always_comb begin
        lead_cnt  = XLEN'(XLEN);   // zero operand
        trail_cnt = XLEN'(XLEN);
        pop_cnt   = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (rs1_i[i]) lead_cnt = XLEN'(XLEN - 1 - i);   // highest set bit wins
            pop_cnt = pop_cnt + XLEN'(rs1_i[i]);
        end
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (rs1_i[i]) trail_cnt = XLEN'(i);   // lowest set bit wins
        end
    end

    always_comb begin
        case (alu_cmd_i.raw)
            cmd_clz:  count_o = lead_cnt;
            cmd_ctz:  count_o = trail_cnt;
            cmd_cpop: count_o = pop_cnt;
            default:  count_o = '0;
        endcase
        assert (count_o <= XLEN) else $error("bit count above XLEN");
    end

endmodule

// ==== hdl/base_int_unit.sv ====
`timescale 1ns/1ps

module base_int_unit import alu_op_pkg::*; #(
    parameter int XLEN = 32
) (
    input  alu_cmd_u          alu_cmd_i,
    input  logic [XLEN-1:0]   rs1_i,
    input  logic [XLEN-1:0]   rs2_i,
    input  logic              less_i,
    output logic [XLEN-1:0]   int_result_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = rs2_i[SHAMT_W-1:0];   // upper bits ignored

    ////////////////////
    // base integer ops
    always_comb begin
        int_result_o = '0;   // unknown codes
        case (alu_cmd_i.raw)
            cmd_add:  int_result_o = rs1_i + rs2_i;
            cmd_sub:  int_result_o = rs1_i - rs2_i;
            cmd_slt,
            cmd_sltu: int_result_o = XLEN'(less_i);   // signedness set in compare
            cmd_xor:  int_result_o = rs1_i ^ rs2_i;
            cmd_or:   int_result_o = rs1_i | rs2_i;
            cmd_and:  int_result_o = rs1_i & rs2_i;
            cmd_sll:  int_result_o = rs1_i << shamt;
            cmd_srl:  int_result_o = rs1_i >> shamt;
            cmd_sra:  int_result_o = $signed(rs1_i) >>> shamt;
            default: begin
                int_result_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/compare_unit.sv ====
`timescale 1ns/1ps

module compare_unit import alu_op_pkg::*, branch_pkg::*; #(
    parameter int XLEN = 32
) (
    input  alu_cmd_u          alu_cmd_i,
    input  logic [2:0]        zero_cmd_i,
    input  logic [XLEN-1:0]   rs1_i,
    input  logic [XLEN-1:0]   rs2_i,
    output logic              less_o,
    output logic              equal_o,
    output logic              branch_flag_o
);

    logic            is_unsigned;
    logic            rs1_ext;
    logic            rs2_ext;
    logic [XLEN:0]   diff;

    assign is_unsigned = alu_cmd_i.raw inside {cmd_sltu, cmd_maxu, cmd_minu};
    assign rs1_ext     = is_unsigned ? 1'b0 : rs1_i[XLEN-1];
    assign rs2_ext     = is_unsigned ? 1'b0 : rs2_i[XLEN-1];

    // one extra bit, so the top bit is the true sign
    assign diff    = {rs1_ext, rs1_i} - {rs2_ext, rs2_i};
    assign less_o  = diff[XLEN];
    assign equal_o = (rs1_i == rs2_i);

    always_comb begin
        case (zero_cmd_i)
            br_eq:   branch_flag_o = equal_o;
            br_ne:   branch_flag_o = ~equal_o;
            br_lt:   branch_flag_o = less_o;
            br_ge:   branch_flag_o = ~less_o;   // equal counts as ge
            default: branch_flag_o = 1'b0;
        endcase
    end

    always_comb begin
        assert (!(less_o && equal_o)) else $error("compare: less and equal both high");
    end

endmodule

// ==== hdl/branch_pkg.sv ====
package branch_pkg;

    ////////////////////
    // branch condition codes on zero_cmd
    localparam logic [2:0] br_none = 3'd0;   // flag held low
    localparam logic [2:0] br_eq   = 3'd1;
    localparam logic [2:0] br_ne   = 3'd2;
    localparam logic [2:0] br_lt   = 3'd3;
    localparam logic [2:0] br_ge   = 3'd4;

endpackage

// ==== hdl/alu_op_pkg.sv ====
package alu_op_pkg;

    ////////////////////
    // base integer group
    localparam logic [6:0] cmd_add    = 7'd1;
    localparam logic [6:0] cmd_slt    = 7'd2;
    localparam logic [6:0] cmd_sltu   = 7'd3;
    localparam logic [6:0] cmd_xor    = 7'd4;
    localparam logic [6:0] cmd_or     = 7'd5;
    localparam logic [6:0] cmd_and    = 7'd6;
    localparam logic [6:0] cmd_sll    = 7'd7;
    localparam logic [6:0] cmd_srl    = 7'd8;
    localparam logic [6:0] cmd_sra    = 7'd9;
    localparam logic [6:0] cmd_sub    = 7'd10;

    ////////////////////
    // bit-manipulation group, bit 6 set
    localparam logic [6:0] cmd_andn   = 7'd64;
    localparam logic [6:0] cmd_clmul  = 7'd65;
    localparam logic [6:0] cmd_clmulh = 7'd66;
    localparam logic [6:0] cmd_clmulr = 7'd67;
    localparam logic [6:0] cmd_clz    = 7'd68;
    localparam logic [6:0] cmd_cpop   = 7'd69;
    localparam logic [6:0] cmd_ctz    = 7'd70;
    localparam logic [6:0] cmd_max    = 7'd71;
    localparam logic [6:0] cmd_maxu   = 7'd72;
    localparam logic [6:0] cmd_min    = 7'd73;
    localparam logic [6:0] cmd_minu   = 7'd74;
    localparam logic [6:0] cmd_orcb   = 7'd75;
    localparam logic [6:0] cmd_orn    = 7'd76;
    localparam logic [6:0] cmd_rev8   = 7'd77;
    localparam logic [6:0] cmd_rol    = 7'd78;
    localparam logic [6:0] cmd_ror    = 7'd79;
    localparam logic [6:0] cmd_bclr   = 7'd80;
    localparam logic [6:0] cmd_bext   = 7'd81;
    localparam logic [6:0] cmd_binv   = 7'd82;
    localparam logic [6:0] cmd_bset   = 7'd83;
    localparam logic [6:0] cmd_sextb  = 7'd84;
    localparam logic [6:0] cmd_sexth  = 7'd85;
    localparam logic [6:0] cmd_sh1add = 7'd86;
    localparam logic [6:0] cmd_sh2add = 7'd87;
    localparam logic [6:0] cmd_sh3add = 7'd88;
    localparam logic [6:0] cmd_xnor   = 7'd89;
    localparam logic [6:0] cmd_zexth  = 7'd90;

    // command word, seen whole or as group bit plus index
    typedef union packed {
        logic [6:0] raw;              // full code
        struct packed {
            logic       b_ext;        // bit-manip group select
            logic [5:0] index;        // code within group
        } fields;
    } alu_cmd_u;

endpackage
